/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Verification passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/d_bank.sv */
`include "dmem_macros.svh"

module d_bank (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  dmem_pkg::bank_acc_t        acc_i,
    output logic [`DMEM_CL_SIZE-1:0]   line_o
);
    localparam int CL_W    = `DMEM_CL_SIZE;
    localparam int BE_W    = CL_W / 8;
    localparam int IDX_CNT = `DMEM_IDX_CNT;

    logic [CL_W-1:0] mem_q [IDX_CNT];
    logic [CL_W-1:0] cur_line;
    logic [CL_W-1:0] wr_line;

    // byte merge of the store into the addressed line
    always_comb begin
        cur_line = mem_q[acc_i.idx];
        wr_line  = cur_line;
        for (int b = 0; b < BE_W; b++) begin
            if (acc_i.be[b]) begin
                wr_line[b*8 +: 8] = acc_i.wline[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < IDX_CNT; i++) begin
                mem_q[i] <= '0;  // defined data for early loads
            end
        end else if (acc_i.valid && acc_i.we) begin
            mem_q[acc_i.idx] <= wr_line;
        end
    end

    // read sees the line before a same-edge write
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_o <= '0;
        end else if (acc_i.valid) begin
            line_o <= cur_line;
        end
    end

endmodule

/* source/d_merge.sv */
`include "dmem_macros.svh"

module d_merge (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       ctl_valid_i,
    input  dmem_pkg::merge_ctl_t       ctl_i,
    input  logic [`DMEM_CL_SIZE-1:0]   line_e_i,
    input  logic [`DMEM_CL_SIZE-1:0]   line_o_i,
    input  logic                       rsp_credit_i,
    output logic                       room_o,
    output logic                       rsp_valid_o,
    output dmem_pkg::mem_rsp_t         rsp_o
);
    import dmem_pkg::*;

    localparam int CL_W     = `DMEM_CL_SIZE;
    localparam int OQ_DEPTH = 2;
    localparam int OQ_PTR_W = $clog2(OQ_DEPTH);
    localparam int OQ_CNT_W = $clog2(OQ_DEPTH + 1);
    localparam int CRED_W   = $clog2(`DMEM_RSP_CREDITS + 1);

    logic                  ctl_vld_q;
    merge_ctl_t            ctl_q;
    logic [CL_W-1:0]       line0;
    logic [CL_W-1:0]       line1;
    logic [2*CL_W-1:0]     pair_sh;
    logic [31:0]           size_mask;
    mem_rsp_t              rsp_new;
    mem_rsp_t              oq_mem [OQ_DEPTH];
    logic [OQ_PTR_W-1:0]   oq_wr_ptr;
    logic [OQ_PTR_W-1:0]   oq_rd_ptr;
    logic [OQ_CNT_W-1:0]   oq_cnt;
    logic [OQ_CNT_W:0]     occ;
    logic [CRED_W-1:0]     cred_q;
    logic                  deq;

    // control waits one cycle for the bank read data
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctl_vld_q <= 1'b0;
        end else begin
            ctl_vld_q <= ctl_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_valid_i) begin
            ctl_q <= ctl_i;
        end
    end

    assign line0   = ctl_q.use_e_as_0 ? line_e_i : line_o_i;
    assign line1   = !ctl_q.need_p1 ? '0 : (ctl_q.use_e_as_0 ? line_o_i : line_e_i);
    assign pair_sh = {line1, line0} >> {ctl_q.offset, 3'b000};

    always_comb begin
        case (ctl_q.size)
            SZ_1B:   size_mask = 32'h0000_00ff;
            SZ_2B:   size_mask = 32'h0000_ffff;
            default: size_mask = 32'hffff_ffff;
        endcase
    end

    assign rsp_new.data = (ctl_q.op == LD) ? (pair_sh[31:0] & size_mask) : '0;  // zero-extended
    assign rsp_new.op   = ctl_q.op;
    assign rsp_new.tag  = ctl_q.tag;

    assign rsp_valid_o = (oq_cnt != '0) && (cred_q != '0);
    assign deq         = rsp_valid_o;
    assign rsp_o       = oq_mem[oq_rd_ptr];

    // queued plus in flight, less what leaves this cycle
    assign occ    = {1'b0, oq_cnt} + (OQ_CNT_W + 1)'(ctl_vld_q);
    assign room_o = (occ - (OQ_CNT_W + 1)'(deq)) < (OQ_CNT_W + 1)'(OQ_DEPTH);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            oq_wr_ptr <= '0;
            oq_rd_ptr <= '0;
            oq_cnt    <= '0;
            cred_q    <= CRED_W'(`DMEM_RSP_CREDITS);
        end else begin
            if (ctl_vld_q) begin
                oq_wr_ptr <= oq_wr_ptr + 1'b1;
            end
            if (deq) begin
                oq_rd_ptr <= oq_rd_ptr + 1'b1;
            end
            oq_cnt <= oq_cnt + OQ_CNT_W'(ctl_vld_q) - OQ_CNT_W'(deq);
            cred_q <= cred_q - CRED_W'(deq) + CRED_W'(rsp_credit_i);
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_vld_q) begin
            oq_mem[oq_wr_ptr] <= rsp_new;
        end
    end

endmodule

/* source/d_split.sv */
`include "dmem_macros.svh"

module d_split (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    input  dmem_pkg::mem_req_t      req_i,
    input  logic                    room_i,
    output logic                    req_credit_o,
    output dmem_pkg::bank_acc_t     bank_e_o,
    output dmem_pkg::bank_acc_t     bank_o_o,
    output logic                    ctl_valid_o,
    output dmem_pkg::merge_ctl_t    ctl_o
);
    import dmem_pkg::*;

    localparam int DEPTH = `DMEM_REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CL_W  = `DMEM_CL_SIZE;
    localparam int BE_W  = CL_W / 8;
    localparam int OFF_W = $clog2(BE_W);
    localparam int IDX_W = $clog2(`DMEM_IDX_CNT);

    mem_req_t             q_mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     q_cnt;
    logic                 pop;
    mem_req_t             head;
    logic                 act;
    logic                 use_e;
    logic                 need_p1;
    logic [OFF_W:0]       nbytes;
    logic [OFF_W:0]       end_byte;
    logic [BE_W-1:0]      base_be;
    logic [2*BE_W-1:0]    be_pair;
    logic [2*CL_W-1:0]    data_pair;
    logic [IDX_W-1:0]     idx0;
    bank_acc_t            acc0;
    bank_acc_t            acc1;

    // credits keep the queue from overflowing
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            q_cnt        <= '0;
            req_credit_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_cnt        <= q_cnt + CNT_W'(req_valid_i) - CNT_W'(pop);
            req_credit_o <= pop;  // one credit back per pop
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            q_mem[wr_ptr] <= req_i;
        end
    end

    assign pop  = (q_cnt != '0) && room_i;
    assign head = q_mem[rd_ptr];
    assign act  = (head.op == LD) || (head.op == ST);

    always_comb begin
        case (head.size)
            SZ_1B:   nbytes = (OFF_W + 1)'(1);
            SZ_2B:   nbytes = (OFF_W + 1)'(2);
            default: nbytes = (OFF_W + 1)'(4);
        endcase
        base_be = BE_W'((1 << nbytes) - 1);
    end

    assign end_byte  = {1'b0, head.addr[OFF_W-1:0]} + nbytes;
    assign need_p1   = end_byte > (OFF_W + 1)'(BE_W);  // crosses into the next line
    assign use_e     = ~head.addr[OFF_W];
    assign idx0      = head.addr[OFF_W+1 +: IDX_W];
    assign be_pair   = {{BE_W{1'b0}}, base_be} << head.addr[OFF_W-1:0];
    assign data_pair = {{(2*CL_W-32){1'b0}}, head.data} << {head.addr[OFF_W-1:0], 3'b000};

    always_comb begin
        acc0.valid = pop && act;
        acc0.we    = head.op == ST;
        acc0.idx   = idx0;
        acc0.be    = be_pair[BE_W-1:0];
        acc0.wline = data_pair[CL_W-1:0];

        acc1.valid = pop && act && need_p1;
        acc1.we    = head.op == ST;
        acc1.idx   = use_e ? idx0 : idx0 + 1'b1;  // odd to even carries the index
        acc1.be    = be_pair[2*BE_W-1:BE_W];
        acc1.wline = data_pair[2*CL_W-1:CL_W];
    end

    assign bank_e_o = use_e ? acc0 : acc1;
    assign bank_o_o = use_e ? acc1 : acc0;

    assign ctl_valid_o      = pop;
    assign ctl_o.use_e_as_0 = use_e;
    assign ctl_o.need_p1    = need_p1;
    assign ctl_o.offset     = head.addr[OFF_W-1:0];
    assign ctl_o.size       = head.size;
    assign ctl_o.op         = act ? head.op : NOOP;
    assign ctl_o.tag        = head.tag;

endmodule

/* source/d_unit_top.sv */
`include "dmem_macros.svh"

module d_unit_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    input  dmem_pkg::mem_req_t      req_i,
    output logic                    req_credit_o,
    output logic                    rsp_valid_o,
    output dmem_pkg::mem_rsp_t      rsp_o,
    input  logic                    rsp_credit_i
);
    import dmem_pkg::*;

    bank_acc_t                  bank_e_acc;
    bank_acc_t                  bank_o_acc;
    merge_ctl_t                 ctl;
    logic                       ctl_valid;
    logic                       room;
    logic [`DMEM_CL_SIZE-1:0]   line_e;
    logic [`DMEM_CL_SIZE-1:0]   line_o;

    d_split u_split (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .room_i       (room),
        .req_credit_o (req_credit_o),
        .bank_e_o     (bank_e_acc),
        .bank_o_o     (bank_o_acc),
        .ctl_valid_o  (ctl_valid),
        .ctl_o        (ctl)
    );

    // even lines, address bit 4 clear
    d_bank bank_e (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .acc_i   (bank_e_acc),
        .line_o  (line_e)
    );

    d_bank bank_o (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .acc_i   (bank_o_acc),
        .line_o  (line_o)
    );

    d_merge u_merge (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ctl_valid_i  (ctl_valid),
        .ctl_i        (ctl),
        .line_e_i     (line_e),
        .line_o_i     (line_o),
        .rsp_credit_i (rsp_credit_i),
        .room_o       (room),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

/* source/dmem_macros.svh */
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// one cache line in bits, 16 bytes
`define DMEM_CL_SIZE 128

// lines in each of the even and odd banks
`define DMEM_IDX_CNT 64

// out-of-order tag carried from request to response
`define DMEM_OOO_TAG_SIZE 10

// request queue entries, equal to the requester credits after reset
`define DMEM_REQ_DEPTH 4

// response credits held by the merge stage after reset
`define DMEM_RSP_CREDITS 2

`endif

/* source/dmem_pkg.sv */
`include "dmem_macros.svh"

package dmem_pkg;

    // only LD and ST act, the rest are kept as encodings
    typedef enum logic [2:0] {
        NOOP  = 3'd0,
        LD    = 3'd1,
        ST    = 3'd2,
        RD    = 3'd3,
        WR    = 3'd4,
        INV   = 3'd5,
        UPD   = 3'd6,
        WR_LD = 3'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        SZ_1B   = 2'd0,
        SZ_2B   = 2'd1,
        SZ_4B   = 2'd2,
        SZ_4B_X = 2'd3  // handled like SZ_4B
    } mem_size_e;

    typedef struct packed {
        logic [31:0]                   addr;
        logic [31:0]                   data;
        mem_size_e                     size;
        mem_op_e                       op;
        logic [`DMEM_OOO_TAG_SIZE-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic                              valid;
        logic                              we;
        logic [$clog2(`DMEM_IDX_CNT)-1:0]  idx;
        logic [`DMEM_CL_SIZE/8-1:0]        be;
        logic [`DMEM_CL_SIZE-1:0]          wline;
    } bank_acc_t;

    typedef struct packed {
        logic                                 use_e_as_0;  // line 0 lives in the even bank
        logic                                 need_p1;     // access spills into line 1
        logic [$clog2(`DMEM_CL_SIZE/8)-1:0]   offset;
        mem_size_e                            size;
        mem_op_e                              op;
        logic [`DMEM_OOO_TAG_SIZE-1:0]        tag;
    } merge_ctl_t;

    typedef struct packed {
        logic [31:0]                   data;
        mem_op_e                       op;
        logic [`DMEM_OOO_TAG_SIZE-1:0] tag;
    } mem_rsp_t;

endpackage

/* tb.f */
+incdir+source
source/dmem_pkg.sv
source/d_split.sv
source/d_bank.sv
source/d_merge.sv
source/d_unit_top.sv
verif/tb_checker.sv
verif/tb_top.sv

/* verif/tb_checker.sv */
`include "dmem_macros.svh"

module tb_checker (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  dmem_pkg::mem_req_t  req_i,
    input  logic                req_credit_i,
    input  logic                rsp_valid_i,
    input  dmem_pkg::mem_rsp_t  rsp_i,
    input  logic                rsp_credit_i,
    input  int                  test_id_i
);
    import dmem_pkg::*;

    logic [7:0] model_mem [2048];  // byte image of address bits 10..0
    mem_rsp_t   exp_q [$];
    int         err_cnt     = 0;
    int         chk_cnt     = 0;
    int         rsp_cnt     = 0;
    int         pending     = 0;
    int         rsp_cred    = `DMEM_RSP_CREDITS;
    int         outstanding = 0;

    function automatic string test_label(input int id);
        case (id)
            1:       return "aligned";
            2:       return "line_cross";
            3:       return "backpressure";
            4:       return "other_ops";
            5:       return "store_load";
            6:       return "drain";
            default: return "reset";
        endcase
    endfunction

    // stores update the byte image in request order
    task automatic predict(input mem_req_t r, output mem_rsp_t p);
        logic [10:0] a;
        int          n;
        a      = r.addr[10:0];
        n      = (r.size == SZ_1B) ? 1 : ((r.size == SZ_2B) ? 2 : 4);
        p.data = '0;
        p.op   = (r.op == LD || r.op == ST) ? r.op : NOOP;
        p.tag  = r.tag;
        for (int i = 0; i < n; i++) begin
            if (r.op == ST) begin
                model_mem[a + 11'(i)] = r.data[i*8 +: 8];  // little-endian
            end else if (r.op == LD) begin
                p.data[i*8 +: 8] = model_mem[a + 11'(i)];
            end
        end
    endtask

    task automatic compare_rsp();
        mem_rsp_t want;
        rsp_cnt++;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("ERROR %s: response with tag %h arrived with no request outstanding",
                     test_label(test_id_i), rsp_i.tag);
        end else begin
            want = exp_q.pop_front();
            chk_cnt++;
            if (rsp_i !== want) begin
                err_cnt++;
                $display("FAIL %s: expected data=%h op=%0d tag=%h, actual data=%h op=%0d tag=%h",
                         test_label(test_id_i), want.data, want.op, want.tag,
                         rsp_i.data, rsp_i.op, rsp_i.tag);
            end
        end
    endtask

    // ports are stable at the falling edge
    always @(negedge clk) begin
        mem_rsp_t p;
        if (!rst_n_i) begin
            foreach (model_mem[i]) begin
                model_mem[i] = 8'h00;  // banks clear at reset
            end
            exp_q.delete();
            rsp_cred    = `DMEM_RSP_CREDITS;
            outstanding = 0;
        end else begin
            if (rsp_valid_i && rsp_cred == 0) begin
                err_cnt++;
                $display("ERROR %s: response sent while the consumer held no credit",
                         test_label(test_id_i));
            end
            if (req_credit_i && outstanding == 0) begin
                err_cnt++;
                $display("ERROR %s: request credit returned with no request outstanding",
                         test_label(test_id_i));
            end
            rsp_cred    = rsp_cred - int'(rsp_valid_i) + int'(rsp_credit_i);
            outstanding = outstanding + int'(req_valid_i) - int'(req_credit_i);
            if (rsp_valid_i) begin
                compare_rsp();
            end
            if (req_valid_i) begin
                predict(req_i, p);
                exp_q.push_back(p);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* verif/tb_top.sv */
`include "dmem_macros.svh"

module tb_top;
    import dmem_pkg::*;

    localparam int          DEPTH   = `DMEM_REQ_DEPTH;
    localparam int          TIMEOUT = 2000;
    localparam logic [31:0] SEED    = 32'h1cef644a;

    logic                          clk;
    logic                          rst_n;
    logic                          req_valid;
    mem_req_t                      req;
    logic                          req_credit;
    logic                          rsp_valid;
    mem_rsp_t                      rsp;
    logic                          rsp_credit = 1'b0;
    logic [31:0]                   req_seed;
    logic [31:0]                   bp_seed    = SEED;
    logic                          bp_en;
    logic                          give       = 1'b0;
    int                            hold       = 0;
    int                            owed       = 0;  // response credits not yet returned
    int                            returned   = 0;
    int                            spent;
    int                            sent;
    int                            tb_checks;
    int                            tb_errs;
    int                            test_id;
    logic                          timed_out;
    logic [`DMEM_OOO_TAG_SIZE-1:0] next_tag;

    d_unit_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_credit_o (req_credit),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp),
        .rsp_credit_i (rsp_credit)
    );

    tb_checker chk (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_credit_i (req_credit),
        .rsp_valid_i  (rsp_valid),
        .rsp_i        (rsp),
        .rsp_credit_i (rsp_credit),
        .test_id_i    (test_id)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        req_seed = lcg_step(req_seed);
        return req_seed;
    endfunction

    function automatic int credits_held();
        return DEPTH - spent + returned;
    endfunction

    function automatic int error_total();
        return chk.err_cnt + tb_errs;
    endfunction

    // credit counting and consumer stalls decided at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            returned = returned + int'(req_credit);
            owed     = owed + int'(rsp_valid);
            if (hold > 0) begin
                hold--;
            end else if (bp_en) begin
                bp_seed = lcg_step(bp_seed);
                if (bp_seed[31:29] == 3'd0) begin
                    hold = int'(bp_seed[15:12]) + 1;  // withhold for 1 to 16 cycles
                end
            end
            give = (owed > 0) && (hold == 0);
            owed = owed - int'(give);
        end
    end

    always @(posedge clk) begin
        #1;
        rsp_credit = give;
    end

    task automatic send_req(input mem_op_e op, input mem_size_e sz,
                            input logic [31:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        while (credits_held() == 0 && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                $display("ERROR %s: no request credit came back within %0d cycles",
                         chk.test_label(test_id), TIMEOUT);
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            req       = '{addr: addr, data: data, size: sz, op: op, tag: next_tag};
            req_valid = 1'b1;
            next_tag++;
            spent++;
            sent++;
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic send_rand(input int mode);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] d;
        mem_size_e   sz;
        mem_op_e     op;
        w  = rand_word();
        d  = rand_word();
        a  = {w[31:11], 3'b000, w[23:16]};  // 256-byte window, upper bits ignored
        sz = mem_size_e'(w[27:26]);
        op = w[30] ? ST : LD;
        if (mode == 1) begin
            a[0] = (sz == SZ_1B) ? a[0] : 1'b0;
            a[1] = sz[1] ? 1'b0 : a[1];
        end else if (mode == 2) begin
            sz     = (sz == SZ_1B) ? SZ_2B : sz;
            a[3:0] = (sz == SZ_2B) ? 4'hf : 4'(13 + int'(w[25:24]) % 3);  // spills past byte 15
        end else if (mode == 4) begin
            op = mem_op_e'(w[14:12]);
            op = (op == LD || op == ST) ? NOOP : op;
        end
        if (mode == 5) begin
            send_req(ST, sz, a, d);
            send_req(LD, mem_size_e'(d[31:30]), a, 32'h0);
        end else begin
            send_req(op, sz, a, d);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        bp_en  = 1'b0;
        while ((chk.pending != 0 || credits_held() != DEPTH) && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                $display("ERROR %s: traffic did not drain within %0d cycles",
                         chk.test_label(test_id), TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_test(input int id, input int n);
        int chk_base;
        int err_base;
        test_id  = id;
        chk_base = chk.chk_cnt;
        err_base = error_total();
        bp_en    = (id == 3);
        for (int i = 0; i < n && !timed_out; i++) begin
            send_rand((id == 4 && i % 3 == 2) ? 3 : id);  // loads show the model untouched
        end
        drain();
        $display("test %0d (%s): %0d checks, %0d errors", id, chk.test_label(id),
                 chk.chk_cnt - chk_base, error_total() - err_base);
    endtask

    initial begin
        int err_base;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        req_seed  = SEED;
        bp_en     = 1'b0;
        spent     = 0;
        sent      = 0;
        tb_checks = 0;
        tb_errs   = 0;
        test_id   = 0;
        timed_out = 1'b0;
        next_tag  = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_test(1, 40);
        run_test(2, 40);
        run_test(3, 80);
        run_test(4, 30);
        run_test(5, 20);

        test_id   = 6;
        err_base  = error_total();
        tb_checks = tb_checks + 2;
        if (chk.rsp_cnt != sent) begin
            tb_errs++;
            $display("FAIL drain: expected %0d responses, actual %0d", sent, chk.rsp_cnt);
        end
        if (credits_held() != DEPTH) begin
            tb_errs++;
            $display("FAIL drain: expected %0d credits, actual %0d", DEPTH, credits_held());
        end
        $display("test 6 (drain): 2 checks, %0d errors", error_total() - err_base);
        $display("summary: %0d requests, %0d checks, %0d errors",
                 sent, chk.chk_cnt + tb_checks, error_total());
        if (error_total() == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
